//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_uartLink
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run into $(LOG), check for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "overridable: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

$(SIM_BIN): $(shell cat $(FLIST)) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All tests passed" $(LOG) || { echo "simulation FAILED, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- baudTickGen.sv
`timescale 1ns/100ps
`default_nettype none

module baudTickGen
    import uartCfgPkg::*;
#(
    parameter int ACC_WIDTH = ACC_WIDTH_DEF,
    parameter int INCREMENT = INCREMENT_DEF
) (
    input wire clk,
    input wire rst,
    output logic sampleTick
);

    logic [ACC_WIDTH-1:0] acc;
    logic [ACC_WIDTH:0] accSum;   // extra bit holds the carry

    assign accSum = {1'b0, acc} + (ACC_WIDTH + 1)'(INCREMENT);

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
            sampleTick <= 1'b0;
        end else begin
            acc <= accSum[ACC_WIDTH-1:0];
            sampleTick <= accSum[ACC_WIDTH];   // one cycle per carry
        end
    end

endmodule

`default_nettype wire

//--- flist.f
uartCfgPkg.sv
uartFramePkg.sv
baudTickGen.sv
uartTransmitter.sv
uartReceiver.sv
uartLink.sv
uartLink_checker.sv
tb_uartLink.sv

//--- tb_uartLink.sv
`timescale 1ns/100ps
`default_nettype none

module tb_uartLink
    import uartCfgPkg::*;
    import uartFramePkg::*;
();

    // bit period in clocks is 16 * 2^ACC_WIDTH / INCREMENT
    localparam int BIT_CLKS = OVERSAMPLE * (2 ** ACC_WIDTH_DEF) / INCREMENT_DEF;
    localparam int TICK_CLKS = BIT_CLKS / OVERSAMPLE;
    localparam int BUSY_LIMIT = 10 * BIT_CLKS + TICK_CLKS;
    localparam int CH_LF = 10;
    localparam int CH_SPACE = 32;
    localparam int CH_HASH = 35;
    localparam int CH_B = 66;   // ascii mode letters
    localparam int CH_D = 68;
    localparam int CH_L = 76;
    localparam int CH_R = 82;

    logic clk;
    logic rst;
    logic txStart;
    uartByteT txData;
    logic rxd;
    logic txd;
    logic txBusy;
    logic rxValid;
    uartByteT rxData;
    logic rxFrameErr;

    logic loopback;
    logic lineReg;
    logic [15:0] lfsr;
    int vectorCount;
    uartByteT rxByteQ[$];
    logic rxErrQ[$];

    assign rxd = loopback ? txd : lineReg;   // line mux outside the DUT

    uartLink UUT (
        .clk(clk),
        .rst(rst),
        .txStart(txStart),
        .txData(txData),
        .rxd(rxd),
        .txd(txd),
        .txBusy(txBusy),
        .rxValid(rxValid),
        .rxData(rxData),
        .rxFrameErr(rxFrameErr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // collect every received strobe at mid-cycle
    always @(negedge clk) begin
        if (!rst && rxValid) begin
            rxByteQ.push_back(rxData);
            rxErrQ.push_back(rxFrameErr);
        end
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run aborted");
    endtask

    task automatic checkByte(input string name, input uartByteT got, input uartByteT exp);
        if (got !== exp) abortRun($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) abortRun($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic waitBusyLow(input int limit, input string what);
        int i;
        for (i = 0; i < limit && txBusy; i++) stepCycle();
        if (txBusy) abortRun({"timeout, txBusy never fell ", what});
    endtask

    task automatic waitRxCount(input int target, input int limit);
        int i;
        for (i = 0; i < limit && rxByteQ.size() < target; i++) stepCycle();
        if (rxByteQ.size() < target) abortRun("timeout, rxValid never arrived for a frame");
    endtask

    task automatic expectOneStrobe(input int first);
        if (rxByteQ.size() != first + 1)
            abortRun($sformatf("expected one rxValid per frame, saw %0d", rxByteQ.size() - first));
    endtask

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic randomByte(output uartByteT b);
        int i;
        for (i = 0; i < 8; i++) begin
            b[i] = lfsr[0];
            lfsr = lfsrNext(lfsr);   // one step per bit
        end
    endtask

    task automatic sendLoopback(input uartByteT b, input logic expErr);
        int first;
        loopback = 1'b1;
        waitBusyLow(BUSY_LIMIT, "before a loopback frame");
        first = rxByteQ.size();
        txData = b;
        txStart = 1'b1;
        stepCycle();
        txStart = 1'b0;
        waitRxCount(first + 1, 12 * BIT_CLKS);
        checkByte("rxData", rxByteQ[first], b);
        checkFlag("rxFrameErr", rxErrQ[first], expErr);
        waitBusyLow(BUSY_LIMIT, "after a loopback frame");
        repeat (BIT_CLKS) stepCycle();   // quiet gap catches a stray strobe
        expectOneStrobe(first);
    endtask

    task automatic driveDirect(input uartByteT b, input logic stopLow);
        int first;
        int i;
        logic [9:0] frame;
        waitBusyLow(BUSY_LIMIT, "before a direct frame");
        lineReg = 1'b1;
        loopback = 1'b0;
        first = rxByteQ.size();
        frame = {~stopLow, b, 1'b0};   // stop, data LSB first, start
        for (i = 0; i < 10; i++) begin
            lineReg = frame[i];
            repeat (BIT_CLKS) stepCycle();
        end
        lineReg = 1'b1;
        waitRxCount(first + 1, 2 * BIT_CLKS);
        checkFlag("rxFrameErr", rxErrQ[first], stopLow);
        if (!stopLow) checkByte("rxData", rxByteQ[first], b);
        repeat (BIT_CLKS) stepCycle();   // high line lets the receiver resync
        expectOneStrobe(first);
    endtask

    task automatic startWhileBusy(input uartByteT b, input logic expErr);
        int first;
        loopback = 1'b1;
        waitBusyLow(BUSY_LIMIT, "before the busy test");
        first = rxByteQ.size();
        txData = b;
        txStart = 1'b1;
        stepCycle();
        txStart = 1'b0;
        repeat (2 * BIT_CLKS) stepCycle();
        checkFlag("txBusy", txBusy, 1'b1);
        txData = ~b;
        txStart = 1'b1;   // should be dropped
        stepCycle();
        txStart = 1'b0;
        waitBusyLow(BUSY_LIMIT - 2 * BIT_CLKS - 1, "within one frame of the accepted start");
        waitRxCount(first + 1, BIT_CLKS);
        checkByte("rxData", rxByteQ[first], b);
        checkFlag("rxFrameErr", rxErrQ[first], expErr);
        repeat (2 * BIT_CLKS) begin
            stepCycle();
            checkFlag("txBusy", txBusy, 1'b0);
        end
        expectOneStrobe(first);
    endtask

    initial begin
        int fd;
        int ch;
        int n;
        int errFlag;
        uartByteT vecByte;
        uartByteT randByte;
        txStart = 1'b0;
        txData = '0;
        lineReg = 1'b1;
        loopback = 1'b1;
        rst = 1'b1;
        lfsr = 16'd24782;
        vectorCount = 0;
        repeat (3) stepCycle();
        rst = 1'b0;
        stepCycle();
        checkFlag("txd", txd, 1'b1);
        checkFlag("txBusy", txBusy, 1'b0);
        checkFlag("rxValid", rxValid, 1'b0);
        checkFlag("rxFrameErr", rxFrameErr, 1'b0);

        fd = $fopen("uartLink_testdata.txt", "r");
        if (fd == 0) abortRun("could not open uartLink_testdata.txt");
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == CH_HASH) begin
                while (ch != CH_LF && ch != -1) ch = $fgetc(fd);
            end else if (ch > CH_SPACE) begin
                n = $fscanf(fd, "%h %d", vecByte, errFlag);
                if (n != 2) abortRun("malformed line in uartLink_testdata.txt");
                case (ch)
                    CH_L: sendLoopback(vecByte, errFlag != 0);
                    CH_D: driveDirect(vecByte, errFlag != 0);
                    CH_B: startWhileBusy(vecByte, errFlag != 0);
                    CH_R: begin
                        randomByte(randByte);
                        sendLoopback(randByte, errFlag != 0);
                    end
                    default: abortRun("unknown mode letter in uartLink_testdata.txt");
                endcase
                vectorCount++;
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);

        if (vectorCount > 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            abortRun("no test vectors were run");
        end
    end

endmodule

`default_nettype wire

//--- uartCfgPkg.sv
`default_nettype none

package uartCfgPkg;

    // accumulator defaults sized for fast simulation
    // a carry every 2^4/4 = 4 clocks
    localparam int ACC_WIDTH_DEF = 4;
    localparam int INCREMENT_DEF = 4;

    localparam int OVERSAMPLE = 16; // ticks per bit slot

endpackage

`default_nettype wire

//--- uartFramePkg.sv
`default_nettype none

package uartFramePkg;

    typedef logic [7:0] uartByteT;  // 8N1 payload

    // index of the data bit within a frame counted from the LSB
    typedef logic [2:0] bitIdxT;

    typedef logic [3:0] tickCntT;   // ticks within one bit slot

endpackage

`default_nettype wire

//--- uartLink.sv
`timescale 1ns/100ps
`default_nettype none

module uartLink
    import uartCfgPkg::*;
    import uartFramePkg::*;
#(
    parameter int ACC_WIDTH = ACC_WIDTH_DEF,
    parameter int INCREMENT = INCREMENT_DEF
) (
    input wire clk,
    input wire rst,
    input wire txStart,
    input wire uartByteT txData,
    input wire rxd,
    output logic txd,
    output logic txBusy,
    output logic rxValid,
    output uartByteT rxData,
    output logic rxFrameErr
);

    logic sampleTick;   // 16x bit rate, shared by both directions

    baudTickGen #(
        .ACC_WIDTH(ACC_WIDTH),
        .INCREMENT(INCREMENT)
    ) tickGen (
        .clk(clk),
        .rst(rst),
        .sampleTick(sampleTick)
    );

    uartTransmitter tx (
        .clk(clk),
        .rst(rst),
        .sampleTick(sampleTick),
        .txStart(txStart),
        .txData(txData),
        .txd(txd),
        .txBusy(txBusy)
    );

    uartReceiver rx (
        .clk(clk),
        .rst(rst),
        .sampleTick(sampleTick),
        .rxd(rxd),
        .rxValid(rxValid),
        .rxData(rxData),
        .rxFrameErr(rxFrameErr)
    );

endmodule

`default_nettype wire

//--- uartLink_checker.sv
`timescale 1ns/100ps
`default_nettype none

module uartLink_checker
    import uartCfgPkg::*;
(
    input wire clk,
    input wire rst,
    input wire sampleTick,
    input wire txd,
    input wire txBusy,
    input wire rxValid
);

    localparam int FRAME_TICKS = 10 * OVERSAMPLE;

    int busyTicks;   // ticks seen while busy

    always_ff @(posedge clk) begin
        if (rst || !txBusy) busyTicks <= 0;
        else if (sampleTick) busyTicks <= busyTicks + 1;
    end

    idleLineHigh: assert property (@(posedge clk) disable iff (rst) !txBusy |-> txd)
        else $error("txd low while the transmitter is idle");

    validOneCycle: assert property (@(posedge clk) disable iff (rst) rxValid |=> !rxValid)
        else $error("rxValid held for more than one cycle");

    // a full frame is 10 slots of 16 ticks
    busyWholeFrame: assert property (@(posedge clk) disable iff (rst)
        $fell(txBusy) |-> busyTicks >= FRAME_TICKS)
        else $error("txBusy fell before a whole frame was sent");

endmodule

bind uartLink uartLink_checker lineChk (
    .clk(clk),
    .rst(rst),
    .sampleTick(sampleTick),
    .txd(txd),
    .txBusy(txBusy),
    .rxValid(rxValid)
);

`default_nettype wire

//--- uartLink_testdata.txt
# columns: mode, byte in hex, expected frame error (1 = drive a low stop bit)
# modes: L loopback, D direct onto rxd, B start while busy, R random loopback (byte unused)
L 55 0
L A3 0
L 00 0
L FF 0
D 3C 0
D 96 1
D 5A 0
D 81 1
D 7E 0
B C7 0
L 12 0
R 00 0
R 00 0
R 00 0
R 00 0
R 00 0
R 00 0

//--- uartReceiver.sv
`timescale 1ns/100ps
`default_nettype none

module uartReceiver
    import uartCfgPkg::*;
    import uartFramePkg::*;
(
    input wire clk,
    input wire rst,
    input wire sampleTick,
    input wire rxd,
    output logic rxValid,
    output uartByteT rxData,
    output logic rxFrameErr
);

    typedef enum logic [2:0] {
        IDLE,
        VERIFY,
        DATA,
        STOP,
        RESYNC
    } rxStateT;

    localparam tickCntT TICK_LAST = tickCntT'(OVERSAMPLE - 1);
    localparam tickCntT TICK_HALF = tickCntT'(OVERSAMPLE / 2);

    rxStateT state;
    tickCntT tickCnt;
    bitIdxT bitIdx;
    uartByteT shiftReg;
    logic rxdMeta;
    logic rxdSync;
    logic sampleNow;

    // two-flop synchronizer that idles high like the line
    always_ff @(posedge clk) begin
        if (rst) begin
            rxdMeta <= 1'b1;
            rxdSync <= 1'b1;
        end else begin
            rxdMeta <= rxd;
            rxdSync <= rxdMeta;
        end
    end

    assign sampleNow = sampleTick && (tickCnt == TICK_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            tickCnt <= '0;
            bitIdx <= '0;
            rxValid <= 1'b0;
            rxFrameErr <= 1'b0;
        end else begin
            rxValid <= 1'b0;
            if (sampleTick) tickCnt <= tickCnt + 1'b1;

            case (state)
                IDLE: begin
                    if (sampleTick && !rxdSync) begin
                        state <= VERIFY;
                        tickCnt <= TICK_HALF;   // first sample lands mid-bit
                    end
                end
                VERIFY: begin
                    if (sampleNow) begin
                        tickCnt <= '0;
                        bitIdx <= '0;
                        state <= rxdSync ? IDLE : DATA;   // high here is a glitch
                    end
                end
                DATA: begin
                    if (sampleNow) begin
                        tickCnt <= '0;
                        if (bitIdx == '1) state <= STOP;
                        else bitIdx <= bitIdx + 1'b1;
                    end
                end
                STOP: begin
                    if (sampleNow) begin
                        rxValid <= 1'b1;
                        rxFrameErr <= !rxdSync;
                        state <= rxdSync ? IDLE : RESYNC;
                    end
                end
                default: begin
                    // wait for a high line before hunting again
                    if (sampleTick && rxdSync) state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DATA && sampleNow) shiftReg <= {rxdSync, shiftReg[7:1]};  // LSB first
        if (state == STOP && sampleNow) rxData <= shiftReg;
    end

endmodule

`default_nettype wire

//--- uartTransmitter.sv
`timescale 1ns/100ps
`default_nettype none

module uartTransmitter
    import uartCfgPkg::*;
    import uartFramePkg::*;
(
    input wire clk,
    input wire rst,
    input wire sampleTick,
    input wire txStart,
    input wire uartByteT txData,
    output logic txd,
    output logic txBusy
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } txStateT;

    localparam tickCntT TICK_LAST = tickCntT'(OVERSAMPLE - 1);

    txStateT state;
    tickCntT tickCnt;
    bitIdxT bitIdx;
    uartByteT dataReg;
    logic slotEnd;

    assign slotEnd = sampleTick && (tickCnt == TICK_LAST);

    // busy already in the accepting cycle
    assign txBusy = (state != IDLE) || txStart;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            tickCnt <= '0;
            bitIdx <= '0;
            txd <= 1'b1;
        end else begin
            if (state == IDLE) begin
                tickCnt <= '0;
                bitIdx <= '0;
            end else if (sampleTick) begin
                tickCnt <= slotEnd ? '0 : tickCnt + 1'b1;
            end

            case (state)
                IDLE: begin
                    txd <= 1'b1;
                    if (txStart) begin
                        state <= START;
                        txd <= 1'b0;    // start bit
                    end
                end
                START: begin
                    if (slotEnd) begin
                        state <= DATA;
                        txd <= dataReg[0];
                    end
                end
                DATA: begin
                    if (slotEnd) begin
                        if (bitIdx == '1) begin
                            state <= STOP;
                            txd <= 1'b1;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                            txd <= dataReg[bitIdx + 1'b1];
                        end
                    end
                end
                default: begin
                    if (slotEnd) state <= IDLE;   // stop slot done
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && txStart) dataReg <= txData;
    end

endmodule

`default_nettype wire
